/* logic/mips_pkg.sv */
package mips_pkg;

    // **************************************************
    // basic types
    // **************************************************

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // **************************************************
    // instruction encodings
    // **************************************************

    // primary opcode field, bits 31..26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f
    } opcode_e;

    // funct field of special opcode
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_SRAV = 6'h07,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_func_e;

    // **************************************************
    // stage payloads
    // **************************************************

    typedef struct packed {
        logic      valid;
        alu_func_e alufunc;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dst;          // 0 means no write
        word_t     imm;          // shamt sits in bits 4..0 for fixed shifts
        logic      use_imm;
        logic      shamt_valid;
        logic      regwrite;
        logic      exception_ri;
    } decoded_instr_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        reg_addr_t dst;
        word_t     data;
        logic      exception_ri;
    } exec_result_t;

endpackage

/* logic/instr_decoder.sv */
module instr_decoder (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     instr_valid,
    input  mips_pkg::word_t          instr,
    output mips_pkg::decoded_instr_t dec
);
    import mips_pkg::*;

    opcode_e        op;
    funct_e         funct;
    reg_addr_t      rs;
    reg_addr_t      rt;
    reg_addr_t      rd;
    logic [4:0]     shamt;
    logic [15:0]    imm16;
    logic           zero_ext;
    logic           is_lui;
    logic           dst_rt;
    decoded_instr_t dec_d;

    // instruction fields
    assign op    = opcode_e'(instr[31:26]);
    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign rd    = instr[15:11];
    assign shamt = instr[10:6];
    assign funct = funct_e'(instr[5:0]);
    assign imm16 = instr[15:0];

    // **************************************************
    // control decode
    // **************************************************

    always_comb begin
        dec_d = '0;
        zero_ext = 1'b0;
        is_lui = 1'b0;
        dst_rt = 1'b1;
        dec_d.valid = 1'b1;
        dec_d.rs = rs;
        dec_d.rt = rt;
        dec_d.regwrite = 1'b1;
        dec_d.use_imm = 1'b1;
        case (op)
            OP_ADDI, OP_ADDIU: dec_d.alufunc = ALU_ADD;
            OP_SLTI:           dec_d.alufunc = ALU_SLT;
            OP_SLTIU:          dec_d.alufunc = ALU_SLTU;
            OP_ANDI: begin
                dec_d.alufunc = ALU_AND;
                zero_ext = 1'b1;
            end
            OP_ORI: begin
                dec_d.alufunc = ALU_OR;
                zero_ext = 1'b1;
            end
            OP_XORI: begin
                dec_d.alufunc = ALU_XOR;
                zero_ext = 1'b1;
            end
            OP_LUI: begin
                dec_d.alufunc = ALU_LUI;
                is_lui = 1'b1;
            end
            OP_RTYPE: begin
                dst_rt = 1'b0;
                dec_d.use_imm = 1'b0;
                case (funct)
                    F_ADD, F_ADDU: dec_d.alufunc = ALU_ADD;
                    F_SUB, F_SUBU: dec_d.alufunc = ALU_SUB;
                    F_AND:         dec_d.alufunc = ALU_AND;
                    F_OR:          dec_d.alufunc = ALU_OR;
                    F_XOR:         dec_d.alufunc = ALU_XOR;
                    F_NOR:         dec_d.alufunc = ALU_NOR;
                    F_SLT:         dec_d.alufunc = ALU_SLT;
                    F_SLTU:        dec_d.alufunc = ALU_SLTU;
                    F_SLLV:        dec_d.alufunc = ALU_SLL;
                    F_SRLV:        dec_d.alufunc = ALU_SRL;
                    F_SRAV:        dec_d.alufunc = ALU_SRA;
                    F_SLL: begin
                        dec_d.alufunc = ALU_SLL;
                        dec_d.shamt_valid = 1'b1;
                    end
                    F_SRL: begin
                        dec_d.alufunc = ALU_SRL;
                        dec_d.shamt_valid = 1'b1;
                    end
                    F_SRA: begin
                        dec_d.alufunc = ALU_SRA;
                        dec_d.shamt_valid = 1'b1;
                    end
                    default: begin
                        dec_d.exception_ri = 1'b1;
                        dec_d.regwrite = 1'b0;
                    end
                endcase
            end
            default: begin
                dec_d.exception_ri = 1'b1;
                dec_d.regwrite = 1'b0;
            end
        endcase

        // immediate / shamt
        if (dec_d.shamt_valid) begin
            dec_d.imm = {27'b0, shamt};
        end else if (is_lui) begin
            dec_d.imm = {imm16, 16'b0};
        end else if (zero_ext) begin
            dec_d.imm = {16'b0, imm16};
        end else begin
            dec_d.imm = {{16{imm16[15]}}, imm16};
        end

        // a write to r0 ends up with dst 0 as well
        dec_d.dst = dst_rt ? rt : rd;
        if (!dec_d.regwrite) begin
            dec_d.dst = '0;
        end
    end

    // idle cycles load an empty slot
    always_ff @(posedge clk) begin
        if (reset) begin
            dec <= '0;
        end else if (instr_valid) begin
            dec <= dec_d;
        end else begin
            dec <= '0;
        end
    end

endmodule

/* logic/alu_execute.sv */
module alu_execute (
    input  mips_pkg::decoded_instr_t dec,
    output mips_pkg::reg_addr_t      rs_addr,
    output mips_pkg::reg_addr_t      rt_addr,
    input  mips_pkg::word_t          rs_data,
    input  mips_pkg::word_t          rt_data,
    output mips_pkg::exec_result_t   exec
);
    import mips_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      result;
    logic [4:0] sh_amt;

    assign rs_addr = dec.rs;
    assign rt_addr = dec.rt;

    assign op_a = rs_data;
    assign op_b = dec.use_imm ? dec.imm : rt_data;

    // fixed shifts take shamt, variable ones take rs
    assign sh_amt = dec.shamt_valid ? dec.imm[4:0] : rs_data[4:0];

    // **************************************************
    // ALU
    // **************************************************

    always_comb begin
        case (dec.alufunc)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_NOR:  result = ~(op_a | op_b);
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, op_a < op_b};
            ALU_SLL:  result = rt_data << sh_amt;
            ALU_SRL:  result = rt_data >> sh_amt;
            ALU_SRA:  result = word_t'($signed(rt_data) >>> sh_amt);
            // immediate already shifted into the upper half
            ALU_LUI:  result = op_b;
            default:  result = '0;
        endcase
    end

    always_comb begin
        exec.valid = dec.valid;
        exec.write = dec.valid & dec.regwrite & ~dec.exception_ri & (dec.dst != '0);
        exec.dst = dec.dst;
        exec.data = dec.exception_ri ? '0 : result;
        exec.exception_ri = dec.valid & dec.exception_ri;
    end

endmodule

/* logic/result_commit.sv */
module result_commit (
    input  logic                   clk,
    input  logic                   reset,
    input  mips_pkg::exec_result_t exec,
    input  mips_pkg::reg_addr_t    rs_addr,
    input  mips_pkg::reg_addr_t    rt_addr,
    output mips_pkg::word_t        rs_data,
    output mips_pkg::word_t        rt_data,
    output logic                   retire_valid,
    output logic                   retire_write,
    output mips_pkg::reg_addr_t    retire_dst,
    output mips_pkg::word_t        retire_data,
    output logic                   retire_exc_ri
);
    import mips_pkg::*;

    word_t        regs [32];
    exec_result_t retire_q;

    // **************************************************
    // register file
    // **************************************************

    // r0 is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (exec.valid && exec.write && exec.dst != '0) begin
            regs[exec.dst] <= exec.data;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    // retire register, loaded on the same edge as the write
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_q <= '0;
        end else begin
            retire_q <= exec;
        end
    end

    assign retire_valid  = retire_q.valid;
    assign retire_write  = retire_q.write;
    assign retire_dst    = retire_q.dst;
    assign retire_data   = retire_q.data;
    assign retire_exc_ri = retire_q.exception_ri;

endmodule

/* logic/mips_alu_core.sv */
module mips_alu_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  mips_pkg::word_t     instr,
    output logic                retire_valid,
    output logic                retire_write,
    output mips_pkg::reg_addr_t retire_dst,
    output mips_pkg::word_t     retire_data,
    output logic                retire_exc_ri
);
    import mips_pkg::*;

    decoded_instr_t dec;
    exec_result_t   exec;
    reg_addr_t      rs_addr;
    reg_addr_t      rt_addr;
    word_t          rs_data;
    word_t          rt_data;

    instr_decoder decoder_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec)
    );

    alu_execute execute_i (
        .dec     (dec),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .exec    (exec)
    );

    result_commit commit_i (
        .clk           (clk),
        .reset         (reset),
        .exec          (exec),
        .rs_addr       (rs_addr),
        .rt_addr       (rt_addr),
        .rs_data       (rs_data),
        .rt_data       (rt_data),
        .retire_valid  (retire_valid),
        .retire_write  (retire_write),
        .retire_dst    (retire_dst),
        .retire_data   (retire_data),
        .retire_exc_ri (retire_exc_ri)
    );

endmodule

/* sim/core_assert.sv */
module core_assert (
    input logic                clk,
    input logic                reset,
    input logic                instr_valid,
    input logic                retire_valid,
    input logic                retire_write,
    input mips_pkg::reg_addr_t retire_dst,
    input logic                retire_exc_ri
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // two edges from acceptance to retire
    retire_latency: assert property (@(posedge clk) disable iff (reset)
        !$past(reset, 1) && !$past(reset, 2) |-> retire_valid == $past(instr_valid, 2))
        else begin
            $error("retire_valid does not follow instr_valid two edges later");
            fail_count++;
        end

    write_not_ri: assert property (@(posedge clk) disable iff (reset)
        retire_write |-> !retire_exc_ri)
        else begin
            $error("retire_write high together with retire_exc_ri");
            fail_count++;
        end

    write_not_r0: assert property (@(posedge clk) disable iff (reset)
        retire_write |-> retire_dst != '0)
        else begin
            $error("retire_write high with destination r0");
            fail_count++;
        end

    // control outputs come out of reset low
    reset_quiet: assert property (@(posedge clk)
        $past(reset) |-> !retire_valid && !retire_write && !retire_exc_ri)
        else begin
            $error("retire control outputs not low after reset");
            fail_count++;
        end

endmodule

bind mips_alu_core core_assert assert_i (
    .clk           (clk),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .retire_valid  (retire_valid),
    .retire_write  (retire_write),
    .retire_dst    (retire_dst),
    .retire_exc_ri (retire_exc_ri)
);

/* sim/core_checker.sv */
module core_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  mips_pkg::word_t     instr,
    input  logic                retire_valid,
    input  logic                retire_write,
    input  mips_pkg::reg_addr_t retire_dst,
    input  mips_pkg::word_t     retire_data,
    input  logic                retire_exc_ri,
    output int                  mismatch_count,
    output int                  protocol_count,
    output int                  pending
);
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    word_t model_regs [32];
    word_t accepted_q [$];
    int    accept_cycle_q [$];
    int    cycle;

    // reference decode straight from the MIPS encodings
    function automatic exec_result_t predict(input word_t ins);
        exec_result_t r;
        word_t        a;
        word_t        b;
        word_t        sext;
        word_t        zext;
        word_t        d;
        reg_addr_t    tgt;
        logic [4:0]   sh;
        logic         bad;
        a = model_regs[ins[25:21]];
        b = model_regs[ins[20:16]];
        sh = ins[10:6];
        sext = {{16{ins[15]}}, ins[15:0]};
        zext = {16'h0, ins[15:0]};
        tgt = ins[20:16];
        bad = 1'b0;
        d = '0;
        case (ins[31:26])
            6'h00: begin
                tgt = ins[15:11];
                case (ins[5:0])
                    6'h00: d = b << sh;
                    6'h02: d = b >> sh;
                    6'h03: d = $signed(b) >>> sh;
                    6'h04: d = b << a[4:0];
                    6'h06: d = b >> a[4:0];
                    6'h07: d = $signed(b) >>> a[4:0];
                    6'h20, 6'h21: d = a + b;
                    6'h22, 6'h23: d = a - b;
                    6'h24: d = a & b;
                    6'h25: d = a | b;
                    6'h26: d = a ^ b;
                    6'h27: d = ~(a | b);
                    6'h2a: d = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b: d = (a < b) ? 32'd1 : 32'd0;
                    default: bad = 1'b1;
                endcase
            end
            6'h08, 6'h09: d = a + sext;
            6'h0a: d = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            6'h0b: d = (a < sext) ? 32'd1 : 32'd0;
            6'h0c: d = a & zext;
            6'h0d: d = a | zext;
            6'h0e: d = a ^ zext;
            6'h0f: d = {ins[15:0], 16'h0};
            default: bad = 1'b1;
        endcase
        r.valid = 1'b1;
        r.exception_ri = bad;
        r.write = !bad && tgt != '0;
        r.dst = bad ? '0 : tgt;
        r.data = bad ? '0 : d;
        return r;
    endfunction

    task automatic check_retire();
        exec_result_t exp;
        word_t        ins;
        int           lat;
        if (accepted_q.size() == 0) begin
            $display("ERROR @%0t: retire_valid with no instruction outstanding", $time);
            protocol_count++;
            return;
        end
        ins = accepted_q.pop_front();
        lat = cycle - accept_cycle_q.pop_front();
        if (lat != 2) begin
            $display("ERROR @%0t: instr %h retired %0d cycles after acceptance",
                     $time, ins, lat);
            protocol_count++;
        end
        exp = predict(ins);
        if (exp.write) begin
            model_regs[exp.dst] = exp.data;
        end
        if (retire_write !== exp.write || retire_dst !== exp.dst ||
                retire_data !== exp.data || retire_exc_ri !== exp.exception_ri) begin
            $display("MISMATCH @%0t: instr %h exp w=%b dst=%0d data=%h ri=%b",
                     $time, ins, exp.write, exp.dst, exp.data, exp.exception_ri);
            $display("    got w=%b dst=%0d data=%h ri=%b",
                     retire_write, retire_dst, retire_data, retire_exc_ri);
            mismatch_count++;
        end
    endtask

    initial begin
        mismatch_count = 0;
        protocol_count = 0;
        pending = 0;
    end

    // sampled on the rising edge, retire outputs still hold the previous cycle
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            accepted_q.delete();
            accept_cycle_q.delete();
            cycle = 0;
        end else begin
            cycle++;
            if (retire_valid) begin
                check_retire();
            end else if (accept_cycle_q.size() != 0 && cycle - accept_cycle_q[0] >= 2) begin
                $display("ERROR @%0t: instr %h accepted at cycle %0d never retired",
                         $time, accepted_q[0], accept_cycle_q[0]);
                protocol_count++;
                accepted_q.delete(0);
                accept_cycle_q.delete(0);
            end
            if (instr_valid) begin
                accepted_q.push_back(instr);
                accept_cycle_q.push_back(cycle);
            end
        end
        pending = accepted_q.size();
    end

endmodule

/* sim/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import mips_pkg::*;

    localparam int N_INSTR    = 2000;
    localparam int CLK_PERIOD = 4;

    // kept encodings picked by index
    localparam logic [5:0] R_FUNCTS [16] = '{
        F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV, F_ADD, F_ADDU,
        F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLTU
    };
    localparam logic [5:0] I_OPCODES [8] = '{
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI
    };

    logic        clk;
    logic        reset;
    logic        instr_valid;
    word_t       instr;
    logic        retire_valid;
    logic        retire_write;
    reg_addr_t   retire_dst;
    word_t       retire_data;
    logic        retire_exc_ri;
    int          mismatch_count;
    int          protocol_count;
    int          pending;
    logic [31:0] lfsr_state;

    mips_alu_core dut_i (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .retire_valid  (retire_valid),
        .retire_write  (retire_write),
        .retire_dst    (retire_dst),
        .retire_data   (retire_data),
        .retire_exc_ri (retire_exc_ri)
    );

    core_checker checker_i (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .retire_valid   (retire_valid),
        .retire_write   (retire_write),
        .retire_dst     (retire_dst),
        .retire_data    (retire_data),
        .retire_exc_ri  (retire_exc_ri),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count),
        .pending        (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // **************************************************
    // random source
    // **************************************************

    // fibonacci lfsr on taps 32 22 2 1
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    // registers limited to r0..r7 so results get reused quickly
    function automatic word_t make_instr();
        logic [1:0]  kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  shamt;
        logic [15:0] imm;
        word_t       w;
        kind  = 2'(draw_bits(2));
        rs    = 5'(draw_bits(3));
        rt    = 5'(draw_bits(3));
        rd    = 5'(draw_bits(3));
        shamt = 5'(draw_bits(5));
        imm   = 16'(draw_bits(16));
        case (kind)
            2'd2: w = {I_OPCODES[3'(draw_bits(3))], rs, rt, imm};
            2'd3: begin
                w = draw_bits(32);
                // half keep the special opcode so unknown functs show up
                if (draw_bits(1) == 32'd1) begin
                    w[31:26] = 6'h00;
                end
            end
            default: w = {6'h00, rs, rt, rd, shamt, R_FUNCTS[4'(draw_bits(4))]};
        endcase
        return w;
    endfunction

    // **************************************************
    // stimulus and end of run
    // **************************************************

    initial begin
        lfsr_state = 32'h9a1a;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int n = 0; n < N_INSTR; n++) begin
            instr_valid = (draw_bits(2) != 32'd0);
            instr = make_instr();
            @(negedge clk);
        end
        instr_valid = 1'b0;
        instr = '0;
        // drain whatever is still in flight
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("errors: %0d mismatches, %0d protocol, %0d assertion",
                 mismatch_count, protocol_count, dut_i.assert_i.fail_count);
        if (mismatch_count == 0 && protocol_count == 0 &&
                dut_i.assert_i.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((N_INSTR + 20) * CLK_PERIOD * 2);
        $display("timeout: the run did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* build.f */
logic/mips_pkg.sv
logic/instr_decoder.sv
logic/alu_execute.sv
logic/result_commit.sv
logic/mips_alu_core.sv
sim/core_assert.sv
sim/core_checker.sv
sim/tb_top.sv
